//--- common/lcd_pkg.sv
package lcd_pkg;

    localparam int SLOT_W = 5;
    localparam int TXT_W  = 16;                      // max chars per line-1 text

    localparam logic [7:0] LINE2_BASE      = 8'h40;
    localparam logic [7:0] PLAY_TIME_ADDR  = 8'h05;
    localparam logic [7:0] SLASH_ADDR      = 8'h0a;
    localparam logic [7:0] TOTAL_TIME_ADDR = 8'h0b;

    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_SLASH = 8'h2f;
    localparam logic [7:0] ASCII_STAR  = 8'h2a;
    localparam logic [7:0] ASCII_COLON = 8'h3a;
    localparam logic [7:0] ASCII_SPACE = 8'h20;
    localparam logic [7:0] ASCII_AT    = 8'h40;

    // right-justified with zero padding on the left
    localparam logic [8*TXT_W-1:0] TXT_IDLE   = "Idle...";
    localparam logic [8*TXT_W-1:0] TXT_PLAY   = "Play";
    localparam logic [8*TXT_W-1:0] TXT_PAUSE  = "Pause";
    localparam logic [8*TXT_W-1:0] TXT_STOP   = "Stop";
    localparam logic [8*TXT_W-1:0] TXT_RECORD = "Recording";

    localparam logic [SLOT_W-1:0] LEN_IDLE   = 5'd7;
    localparam logic [SLOT_W-1:0] LEN_PLAY   = 5'd4;
    localparam logic [SLOT_W-1:0] LEN_PAUSE  = 5'd5;
    localparam logic [SLOT_W-1:0] LEN_STOP   = 5'd4;
    localparam logic [SLOT_W-1:0] LEN_RECORD = 5'd9;

    localparam logic [SLOT_W-1:0] TIME_SLOTS       = 5'd5;  // mm:ss
    localparam logic [SLOT_W-1:0] PLAY_FIELD_SLOTS = 5'd6;  // mm:ss plus slash

    typedef enum logic [3:0] {
        REC_NONE   = 4'd0,
        REC_PLAY   = 4'd1,
        REC_PAUSE  = 4'd2,
        REC_STOP   = 4'd3,
        REC_RECORD = 4'd4
    } rec_code_e;

    typedef enum logic [1:0] {
        REC_NORMAL = 2'd0,
        REC_SLOW   = 2'd1,
        REC_FAST   = 2'd2
    } rec_mode_e;

    typedef struct packed {
        logic [3:0] code;                            // rec_code_e or an undefined value
        logic [1:0] mode;                            // rec_mode_e where 3 acts as normal
        logic [3:0] speed;
        logic       interpol;
        logic [4:0] unused;
    } status_t;

    typedef struct packed {
        logic [3:0] min_ten;
        logic [3:0] min_one;
        logic [3:0] sec_ten;
        logic [3:0] sec_one;
    } bcd_time_t;

    typedef struct packed {
        status_t   status;
        bcd_time_t play_time;
        bcd_time_t total_time;
    } frame_t;

    typedef enum logic [3:0] {
        GLYPH_LITERAL,
        GLYPH_PLAY_MT,
        GLYPH_PLAY_MO,
        GLYPH_PLAY_ST,
        GLYPH_PLAY_SO,
        GLYPH_TOT_MT,
        GLYPH_TOT_MO,
        GLYPH_TOT_ST,
        GLYPH_TOT_SO,
        GLYPH_SPEED,
        GLYPH_INTERPOL
    } glyph_sel_e;

    typedef enum logic {
        LCD_WRITE = 1'b0,
        LCD_CLEAR = 1'b1
    } lcd_op_e;

    typedef struct packed {
        lcd_op_e    op;
        logic [7:0] address;
        glyph_sel_e sel;
        logic [7:0] literal;
        logic       last;                            // final slot of the pass
        logic [3:0] pad;
    } glyph_req_t;

    typedef struct packed {
        lcd_op_e    op;
        logic [7:0] address;
        logic [7:0] character;
    } lcd_cmd_t;

endpackage

//--- screen/screen_sequencer.sv
module screen_sequencer
    import lcd_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  status_t           status,
    input  bcd_time_t         play_time,
    input  bcd_time_t         total_time,
    input  glyph_req_t        layout,                // entry for current slot
    output frame_t            frame,
    output logic [SLOT_W-1:0] slot,
    output glyph_req_t        req,
    output logic              req_valid,
    input  logic              req_ready
);
    typedef enum logic [1:0] {
        ST_CLEAR = 2'd0,
        ST_WRITE = 2'd1,
        ST_REST  = 2'd2
    } state_e;

    state_e     state;
    logic       running;                             // low until first edge after reset
    logic       accept;
    logic       take_snapshot;
    glyph_req_t clear_req;

    assign req_valid     = running && (state != ST_REST);
    assign accept        = req_valid && req_ready;
    assign take_snapshot = !running || (state == ST_REST);

    always_comb begin
        clear_req         = '0;
        clear_req.op      = LCD_CLEAR;
        clear_req.sel     = GLYPH_LITERAL;
        clear_req.address = 8'h00;
    end

    assign req = (state == ST_CLEAR) ? clear_req : layout;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state   <= ST_CLEAR;
            slot    <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                ST_CLEAR: begin
                    if (accept) begin
                        state <= ST_WRITE;
                        slot  <= '0;
                    end
                end
                ST_WRITE: begin
                    if (accept) begin
                        if (layout.last) begin
                            state <= ST_REST;
                            slot  <= '0;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                end
                ST_REST: begin
                    // new status means a fresh screen, else just refresh
                    if (status != frame.status) begin
                        state <= ST_CLEAR;
                    end else begin
                        state <= ST_WRITE;
                    end
                    slot <= '0;
                end
                default: begin
                    state <= ST_CLEAR;
                    slot  <= '0;
                end
            endcase
        end
    end

    // pass snapshot stays stable while req_valid is high
    always_ff @(posedge i_clk) begin
        if (take_snapshot) begin
            frame.status     <= status;
            frame.play_time  <= play_time;
            frame.total_time <= total_time;
        end
    end

endmodule

//--- screen/message_rom.sv
module message_rom
    import lcd_pkg::*;
(
    input  frame_t            frame,
    input  logic [SLOT_W-1:0] slot,
    output glyph_req_t        layout
);
    logic [8*TXT_W-1:0] txt;
    logic [SLOT_W-1:0]  txt_len;
    logic [SLOT_W-1:0]  txt_pos;
    logic [SLOT_W-1:0]  line1_len;
    logic [SLOT_W-1:0]  k;                           // slot within time fields
    logic [SLOT_W-1:0]  kt;                          // slot within total time
    logic [SLOT_W-1:0]  k2;                          // slot within line 2
    logic               has_play;
    logic               has_total;
    logic               mode_shown;

    function automatic glyph_sel_e time_sel(input logic [SLOT_W-1:0] idx, input logic total);
        case (idx)
            5'd0:    return total ? GLYPH_TOT_MT : GLYPH_PLAY_MT;
            5'd1:    return total ? GLYPH_TOT_MO : GLYPH_PLAY_MO;
            5'd3:    return total ? GLYPH_TOT_ST : GLYPH_PLAY_ST;
            5'd4:    return total ? GLYPH_TOT_SO : GLYPH_PLAY_SO;
            default: return GLYPH_LITERAL;           // the colon
        endcase
    endfunction

    always_comb begin
        has_play  = 1'b0;
        has_total = 1'b0;
        case (frame.status.code)
            REC_PLAY: begin
                txt       = TXT_PLAY;
                txt_len   = LEN_PLAY;
                has_play  = 1'b1;
                has_total = 1'b1;
            end
            REC_PAUSE: begin
                txt     = TXT_PAUSE;
                txt_len = LEN_PAUSE;
            end
            REC_STOP: begin
                txt     = TXT_STOP;
                txt_len = LEN_STOP;
            end
            REC_RECORD: begin
                txt       = TXT_RECORD;
                txt_len   = LEN_RECORD;
                has_total = 1'b1;
            end
            default: begin                           // undefined codes too
                txt     = TXT_IDLE;
                txt_len = LEN_IDLE;
            end
        endcase
        line1_len = txt_len + (has_play ? PLAY_FIELD_SLOTS : 5'd0)
                  + (has_total ? TIME_SLOTS : 5'd0);
    end

    assign txt_pos    = txt_len - 5'd1 - slot;
    assign k          = slot - txt_len;
    assign kt         = has_play ? k - PLAY_FIELD_SLOTS : k;
    assign k2         = slot - line1_len;
    assign mode_shown = (frame.status.mode == REC_SLOW) || (frame.status.mode == REC_FAST);

    always_comb begin
        layout     = '0;
        layout.op  = LCD_WRITE;
        layout.sel = GLYPH_LITERAL;
        if (slot < txt_len) begin
            layout.address = 8'(slot);
            layout.literal = txt[{txt_pos[3:0], 3'b000} +: 8];
        end else if (slot < line1_len) begin
            if (has_play && (k < PLAY_FIELD_SLOTS)) begin
                if (k == TIME_SLOTS) begin
                    layout.address = SLASH_ADDR;
                    layout.literal = ASCII_SLASH;
                end else begin
                    layout.address = PLAY_TIME_ADDR + 8'(k);
                    layout.sel     = time_sel(k, 1'b0);
                    layout.literal = ASCII_COLON;
                end
            end else begin
                layout.address = TOTAL_TIME_ADDR + 8'(kt);
                layout.sel     = time_sel(kt, 1'b1);
                layout.literal = ASCII_COLON;
            end
        end else if (mode_shown) begin
            case (k2)
                5'd0: begin
                    layout.address = LINE2_BASE;
                    layout.literal = (frame.status.mode == REC_SLOW) ? ASCII_SLASH : ASCII_STAR;
                end
                5'd1: begin
                    layout.address = LINE2_BASE + 8'd1;
                    layout.sel     = GLYPH_SPEED;
                end
                5'd2: begin
                    layout.address = LINE2_BASE + 8'd2;
                    layout.literal = ASCII_SPACE;
                end
                default: begin
                    layout.address = LINE2_BASE + 8'd3;
                    layout.sel     = GLYPH_INTERPOL;
                    layout.last    = 1'b1;
                end
            endcase
        end else begin
            // normal mode writes only the interpolation flag
            layout.address = LINE2_BASE + 8'd3;
            layout.sel     = GLYPH_INTERPOL;
            layout.last    = 1'b1;
        end
    end

endmodule

//--- screen/glyph_formatter.sv
module glyph_formatter
    import lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  frame_t     frame,
    input  glyph_req_t req,
    input  logic       req_valid,
    output logic       req_ready,
    output lcd_cmd_t   cmd,
    output logic       cmd_valid,
    input  logic       cmd_ready
);
    logic [3:0] digit;
    logic       is_digit;
    logic [7:0] character;
    logic       accept;

    always_comb begin
        digit    = 4'h0;
        is_digit = 1'b1;
        case (req.sel)
            GLYPH_PLAY_MT: digit = frame.play_time.min_ten;
            GLYPH_PLAY_MO: digit = frame.play_time.min_one;
            GLYPH_PLAY_ST: digit = frame.play_time.sec_ten;
            GLYPH_PLAY_SO: digit = frame.play_time.sec_one;
            GLYPH_TOT_MT:  digit = frame.total_time.min_ten;
            GLYPH_TOT_MO:  digit = frame.total_time.min_one;
            GLYPH_TOT_ST:  digit = frame.total_time.sec_ten;
            GLYPH_TOT_SO:  digit = frame.total_time.sec_one;
            GLYPH_SPEED:   digit = frame.status.speed;
            default:       is_digit = 1'b0;
        endcase
    end

    always_comb begin
        if (is_digit) begin
            character = ASCII_ZERO + {4'h0, digit};
        end else if (req.sel == GLYPH_INTERPOL) begin
            character = frame.status.interpol ? ASCII_AT : ASCII_ZERO;
        end else begin
            character = req.literal;
        end
    end

    assign req_ready = !cmd_valid || cmd_ready;      // empty or draining now
    assign accept    = req_valid && req_ready;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cmd_valid <= 1'b0;
        end else if (accept) begin
            cmd_valid <= 1'b1;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd.op        <= req.op;
            cmd.address   <= req.address;
            cmd.character <= character;
        end
    end

endmodule

//--- verilog/lcd_display_top.sv
module lcd_display_top
    import lcd_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  status_t   status,
    input  bcd_time_t play_time,
    input  bcd_time_t total_time,
    output lcd_cmd_t  cmd,
    output logic      cmd_valid,
    input  logic      cmd_ready                      // LCD not busy
);
    frame_t            frame;
    logic [SLOT_W-1:0] slot;
    glyph_req_t        layout;
    glyph_req_t        req;
    logic              req_valid;
    logic              req_ready;

    screen_sequencer u_sequencer (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .status     (status),
        .play_time  (play_time),
        .total_time (total_time),
        .layout     (layout),
        .frame      (frame),
        .slot       (slot),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready)
    );

    message_rom u_rom (
        .frame  (frame),
        .slot   (slot),
        .layout (layout)
    );

    glyph_formatter u_formatter (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .frame     (frame),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

endmodule

//--- dv/lcd_display_assertions.sv
module lcd_display_assertions
    import lcd_pkg::*;
(
    input logic     i_clk,
    input logic     i_rst,
    input lcd_cmd_t cmd,
    input logic     cmd_valid,
    input logic     cmd_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    property cmd_stable_p;
        @(posedge i_clk) disable iff (i_rst)
        (cmd_valid && !cmd_ready) |=> $stable(cmd);
    endproperty

    property valid_hold_p;
        @(posedge i_clk) disable iff (i_rst)
        (cmd_valid && !cmd_ready) |=> cmd_valid;
    endproperty

    property valid_low_in_reset_p;
        @(posedge i_clk) i_rst |-> !cmd_valid;
    endproperty

    assert property (cmd_stable_p) else $error("cmd changed while the LCD was busy");
    assert property (valid_hold_p) else $error("cmd_valid dropped before the transfer");
    assert property (valid_low_in_reset_p) else $error("cmd_valid high during reset");

endmodule

bind glyph_formatter lcd_display_assertions u_assertions (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready)
);

//--- dv/tb_lcd_display.sv
module tb_lcd_display
    import lcd_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_STALL = 4;           // ready forced high after this many lows
    localparam logic [31:0] LCG_SEED  = 32'h7d8a_4d80;

    logic      i_clk;
    logic      i_rst;
    status_t   status;
    bcd_time_t play_time;
    bcd_time_t total_time;
    lcd_cmd_t  cmd;
    logic      cmd_valid;
    logic      cmd_ready;

    frame_t      row_frame[$];                       // stimulus
    string       row_text[$];                        // expected line-1 text per row
    lcd_cmd_t    expq[$];                            // commands of the pass in flight
    frame_t      live;
    string       live_text;
    frame_t      snap;                               // model of the DUT snapshot
    logic [31:0] lcg;
    int          stall_run;
    int          n_checked;
    int          n_value_err;
    int          n_proto_err;
    logic        table_ready;

    lcd_display_top UUT (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .status     (status),
        .play_time  (play_time),
        .total_time (total_time),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] ascii_digit(input logic [3:0] d);
        return 8'h30 + {4'h0, d};
    endfunction

    task automatic add_row(input logic [3:0] code, input logic [1:0] mode, input logic [3:0] speed,
                           input logic interpol, input bcd_time_t play, input bcd_time_t total,
                           input string text);
        frame_t f;
        f                   = '0;
        f.status.code       = code;
        f.status.mode       = mode;
        f.status.speed      = speed;
        f.status.interpol   = interpol;
        f.play_time         = play;
        f.total_time        = total;
        row_frame.push_back(f);
        row_text.push_back(text);
    endtask

    task automatic load_table();
        add_row(REC_NONE,   REC_NORMAL, 4'd0, 1'b1, 16'h0000, 16'h0000, "Idle...");
        add_row(REC_PLAY,   REC_NORMAL, 4'd1, 1'b0, 16'h0125, 16'h0430, "Play");
        add_row(REC_PLAY,   REC_NORMAL, 4'd1, 1'b0, 16'h0126, 16'h0430, "Play"); // times only
        add_row(REC_PLAY,   REC_SLOW,   4'd2, 1'b1, 16'h0127, 16'h0430, "Play");
        add_row(REC_PLAY,   REC_FAST,   4'd4, 1'b0, 16'h3958, 16'h5909, "Play");
        add_row(REC_PAUSE,  REC_FAST,   4'd8, 1'b1, 16'h1111, 16'h2222, "Pause");
        add_row(REC_STOP,   REC_SLOW,   4'd3, 1'b0, 16'h0000, 16'h0000, "Stop");
        add_row(REC_RECORD, REC_NORMAL, 4'd0, 1'b1, 16'h0000, 16'h1234, "Recording");
        add_row(REC_RECORD, REC_NORMAL, 4'd0, 1'b1, 16'h0000, 16'h1235, "Recording");
        add_row(REC_RECORD, 2'd3,       4'd5, 1'b0, 16'h0000, 16'h0807, "Recording");
        add_row(4'd9,       REC_SLOW,   4'd7, 1'b1, 16'h0000, 16'h0000, "Idle..."); // undefined
        add_row(REC_NONE,   REC_NORMAL, 4'd0, 1'b0, 16'h0000, 16'h0000, "Idle...");
    endtask

    task automatic push(input lcd_op_e op, input logic [7:0] addr, input logic [7:0] ch);
        lcd_cmd_t c;
        c.op        = op;
        c.address   = addr;
        c.character = ch;
        expq.push_back(c);
    endtask

    task automatic push_time(input logic [7:0] base, input bcd_time_t t);
        push(LCD_WRITE, base,        ascii_digit(t.min_ten));
        push(LCD_WRITE, base + 8'd1, ascii_digit(t.min_one));
        push(LCD_WRITE, base + 8'd2, ":");
        push(LCD_WRITE, base + 8'd3, ascii_digit(t.sec_ten));
        push(LCD_WRITE, base + 8'd4, ascii_digit(t.sec_one));
    endtask

    // expected command list of one pass
    task automatic push_pass(input frame_t f, input logic with_clear, input string text);
        if (with_clear) push(LCD_CLEAR, 8'h00, 8'h00);
        for (int i = 0; i < text.len(); i++) begin
            push(LCD_WRITE, 8'(i), text[i]);
        end
        if (f.status.code == REC_PLAY) begin
            push_time(8'h05, f.play_time);
            push(LCD_WRITE, 8'h0a, "/");
        end
        if (f.status.code == REC_PLAY || f.status.code == REC_RECORD) begin
            push_time(8'h0b, f.total_time);
        end
        if (f.status.mode == REC_SLOW || f.status.mode == REC_FAST) begin
            push(LCD_WRITE, 8'h40, (f.status.mode == REC_SLOW) ? "/" : "*");
            push(LCD_WRITE, 8'h41, ascii_digit(f.status.speed));
            push(LCD_WRITE, 8'h42, " ");
        end
        push(LCD_WRITE, 8'h43, f.status.interpol ? "@" : "0");
    endtask

    // DUT takes its snapshot right after the last slot, so live is what it saw
    task automatic queue_pass(input logic first);
        logic clear;
        clear = first || (live.status != snap.status);
        snap  = live;
        push_pass(snap, clear, live_text);
    endtask

    task automatic check_transfer();
        lcd_cmd_t e;
        logic     ok;
        string    got;
        n_checked++;
        assert (expq.size() != 0) else begin
            n_proto_err++;
            $display("transfer at %0t ns arrived when no command was expected", $time);
        end
        if (expq.size() != 0) begin
            e   = expq.pop_front();
            ok  = (cmd.op == e.op) && ((e.op == LCD_CLEAR) ||
                  (cmd.address == e.address && cmd.character == e.character));
            got = $sformatf("op %0d addr %02h char %02h", cmd.op, cmd.address, cmd.character);
            assert (ok) else begin
                n_value_err++;
                $display("[ERROR] %0t ns: got %s, expected op %0d addr %02h char %02h",
                         $time, got, e.op, e.address, e.character);
            end
        end
    endtask

    task automatic tick();
        @(negedge i_clk);
        lcg = lcg_next(lcg);
        if (stall_run >= MAX_STALL || lcg[31:30] != 2'b00) begin
            cmd_ready = 1'b1;
            stall_run = 0;
        end else begin
            cmd_ready = 1'b0;
            stall_run++;
        end
        if (cmd_valid && cmd_ready) check_transfer();   // transfer on the coming edge
    endtask

    task automatic drain();
        while (expq.size() != 0) tick();
    endtask

    task automatic apply_row(input frame_t f, input string text);
        live       = f;
        live_text  = text;
        status     = f.status;
        play_time  = f.play_time;
        total_time = f.total_time;
    endtask

    initial begin
        i_rst       = 1'b1;
        cmd_ready   = 1'b0;
        status      = '0;
        play_time   = '0;
        total_time  = '0;
        live        = '0;
        snap        = '0;
        live_text   = "Idle...";
        lcg         = LCG_SEED;
        stall_run   = 0;
        n_checked   = 0;
        n_value_err = 0;
        n_proto_err = 0;
        table_ready = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (2) @(negedge i_clk);
        i_rst = 1'b0;
        queue_pass(1'b1);
        // next pass is already snapshotted, so a new row shows one pass later
        for (int i = 0; i <= row_frame.size(); i++) begin
            drain();
            queue_pass(1'b0);
            tick();
            if (i < row_frame.size()) apply_row(row_frame[i], row_text[i]);
        end
        drain();
        $display("checked %0d transfers, %0d value errors, %0d protocol errors",
                 n_checked, n_value_err, n_proto_err);
        if (n_value_err == 0 && n_proto_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // rows x 3 passes x 20 commands x worst stall per command
    initial begin
        wait (table_ready);
        #(row_frame.size() * 3 * 20 * (MAX_STALL + 2) * 4 + 100);
        $display("watchdog expired, the command stream did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- build.f
common/lcd_pkg.sv
screen/screen_sequencer.sv
screen/message_rom.sv
screen/glyph_formatter.sv
verilog/lcd_display_top.sv
dv/lcd_display_assertions.sv
dv/tb_lcd_display.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert --timing --timescale 1ns/1ps -j 0
TOP      := tb_lcd_display
FILELIST := build.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := SIMULATION FAILED
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
